// File: common/riscvPkg.sv
`default_nettype none

package riscvPkg;

    // Major opcodes handled by this slice
    localparam logic [6:0] opcodeOp    = 7'b0110011; // Register-register
    localparam logic [6:0] opcodeOpImm = 7'b0010011; // Register-immediate

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] funct3AddSub = 3'b000;
    localparam logic [2:0] funct3Sll    = 3'b001;
    localparam logic [2:0] funct3Slt    = 3'b010;
    localparam logic [2:0] funct3Sltu   = 3'b011;
    localparam logic [2:0] funct3Xor    = 3'b100;
    localparam logic [2:0] funct3SrlSra = 3'b101;
    localparam logic [2:0] funct3Or     = 3'b110;
    localparam logic [2:0] funct3And    = 3'b111;

    // funct7 values
    localparam logic [6:0] funct7Base = 7'b0000000; // Plain op
    localparam logic [6:0] funct7Alt  = 7'b0100000; // sub / sra / srai

    // R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    // I-type layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields;

    // One instruction word, two views
    // Opcode, rd, funct3 and rs1 sit at the same bits in both
    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instrWord;

endpackage

`default_nettype wire

// File: common/execPkg.sv
`default_nettype none

package execPkg;

    localparam int dataWidth    = 32; // XLEN for RV32I
    localparam int regAddrWidth = 5;  // x0..x31
    localparam int regCount     = 32;
    localparam int shamtWidth   = 5;  // Shift amount bits used out of an operand

    // Internal ALU operation codes
    // Decoder produces them, aluUnit consumes them
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,  // Signed compare
        aluSltu = 4'd4,  // Unsigned compare
        aluXor  = 4'd5,
        aluSrl  = 4'd6,  // Logical right
        aluSra  = 4'd7,  // Arithmetic right
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOp;

endpackage

`default_nettype wire

// File: design/instrReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module instrReceiver (
    input  logic               clock,
    input  logic               reset,
    input  logic               instrReq,    // Four-phase request from source
    input  riscvPkg::instrWord instr,       // Held stable while instrReq is high
    output logic               instrAck,
    output logic               issue,       // One-cycle pulse per accepted word
    output riscvPkg::instrWord issuedInstr
);

    logic acceptNow;

    // New request seen while idle
    assign acceptNow = instrReq && !instrAck;

    // Handshake state
    always_ff @(posedge clock) begin
        if (reset) begin
            instrAck <= 1'b0;
            issue    <= 1'b0;
        end else begin
            issue <= 1'b0; // Default low, pulses only on accept
            if (acceptNow) begin
                instrAck <= 1'b1;
                issue    <= 1'b1;
            end else if (!instrReq && instrAck) begin
                // Request dropped, back to idle
                instrAck <= 1'b0;
            end
        end
    end

    // Word capture on the rising phase only
    // Stays put until the next accept
    always_ff @(posedge clock) begin
        if (acceptNow) begin
            issuedInstr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               issue,
    input  riscvPkg::instrWord                 issuedInstr,
    output logic [execPkg::regAddrWidth-1:0]   rs1,        // To register file, combinational
    output logic [execPkg::regAddrWidth-1:0]   rs2,
    output logic                               readEn,
    output logic [execPkg::regAddrWidth-1:0]   rd,         // Staged, lines up with read data
    output execPkg::aluOp                      aluOp,
    output logic                               useImm,
    output logic [execPkg::dataWidth-1:0]      operandImm,
    output logic                               opValid
);

    logic                          baseFunct;
    logic                          altFunct;
    logic                          nextLegal;
    logic                          nextUseImm;
    execPkg::aluOp                 nextOp;
    logic [execPkg::dataWidth-1:0] signImm;
    logic [execPkg::dataWidth-1:0] shiftImm;
    logic [execPkg::dataWidth-1:0] nextImm;

    // Read addresses straight from the word
    // rs2 is don't-care for I-type, the read is harmless
    assign rs1    = issuedInstr.r.rs1;
    assign rs2    = issuedInstr.r.rs2;
    assign readEn = issue;

    // funct7 field, also the upper imm bits of a shift-immediate
    assign baseFunct = issuedInstr.r.funct7 == riscvPkg::funct7Base;
    assign altFunct  = issuedInstr.r.funct7 == riscvPkg::funct7Alt;

    assign signImm  = {{(execPkg::dataWidth-12){issuedInstr.i.imm12[11]}}, issuedInstr.i.imm12};
    assign shiftImm = {{(execPkg::dataWidth-execPkg::shamtWidth){1'b0}},
                       issuedInstr.i.imm12[execPkg::shamtWidth-1:0]};

    always_comb begin
        nextOp     = execPkg::aluAdd;
        nextUseImm = 1'b0;
        nextImm    = signImm;
        nextLegal  = 1'b0; // Unknown opcode is a no-op
        case (issuedInstr.r.opcode)
            riscvPkg::opcodeOp: begin
                // Alt funct7 only valid on sub and sra
                nextLegal = baseFunct ||
                            (altFunct && (issuedInstr.r.funct3 == riscvPkg::funct3AddSub ||
                                          issuedInstr.r.funct3 == riscvPkg::funct3SrlSra));
                case (issuedInstr.r.funct3)
                    riscvPkg::funct3AddSub: nextOp = altFunct ? execPkg::aluSub : execPkg::aluAdd;
                    riscvPkg::funct3Sll:    nextOp = execPkg::aluSll;
                    riscvPkg::funct3Slt:    nextOp = execPkg::aluSlt;
                    riscvPkg::funct3Sltu:   nextOp = execPkg::aluSltu;
                    riscvPkg::funct3Xor:    nextOp = execPkg::aluXor;
                    riscvPkg::funct3SrlSra: nextOp = altFunct ? execPkg::aluSra : execPkg::aluSrl;
                    riscvPkg::funct3Or:     nextOp = execPkg::aluOr;
                    default:                nextOp = execPkg::aluAnd;
                endcase
            end
            riscvPkg::opcodeOpImm: begin
                nextUseImm = 1'b1;
                nextLegal  = 1'b1;
                case (issuedInstr.i.funct3)
                    riscvPkg::funct3AddSub: nextOp = execPkg::aluAdd; // No subi
                    riscvPkg::funct3Slt:    nextOp = execPkg::aluSlt;
                    riscvPkg::funct3Sltu:   nextOp = execPkg::aluSltu; // Sign-extended, compared unsigned
                    riscvPkg::funct3Xor:    nextOp = execPkg::aluXor;
                    riscvPkg::funct3Or:     nextOp = execPkg::aluOr;
                    riscvPkg::funct3And:    nextOp = execPkg::aluAnd;
                    riscvPkg::funct3Sll: begin
                        nextOp    = execPkg::aluSll;
                        nextImm   = shiftImm;
                        nextLegal = baseFunct; // slli has no alt form
                    end
                    default: begin
                        // srli / srai picked by the funct7 view of imm12
                        nextOp    = altFunct ? execPkg::aluSra : execPkg::aluSrl;
                        nextImm   = shiftImm;
                        nextLegal = baseFunct || altFunct;
                    end
                endcase
            end
            default: begin
                nextLegal = 1'b0;
            end
        endcase
    end

    // Valid bit, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            opValid <= 1'b0;
        end else begin
            opValid <= issue && nextLegal;
        end
    end

    // Staged payload, same edge as the register read
    always_ff @(posedge clock) begin
        if (issue) begin
            aluOp      <= nextOp;
            useImm     <= nextUseImm;
            operandImm <= nextImm;
            rd         <= issuedInstr.r.rd;
        end
    end

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [execPkg::regAddrWidth-1:0] readAddr1,
    input  logic [execPkg::regAddrWidth-1:0] readAddr2,
    input  logic                             readEn,    // Both ports update together
    input  logic                             writeEn,
    input  logic [execPkg::regAddrWidth-1:0] writeAddr,
    input  logic [execPkg::dataWidth-1:0]    writeData,
    output logic [execPkg::dataWidth-1:0]    readData1,
    output logic [execPkg::dataWidth-1:0]    readData2
);

    logic [execPkg::dataWidth-1:0] regs [execPkg::regCount];

    // Storage, all words cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < execPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            // x0 never written, so it keeps reading zero
            regs[writeAddr] <= writeData;
        end
    end

    // Registered read ports
    always_ff @(posedge clock) begin
        if (readEn) begin
            readData1 <= regs[readAddr1];
            readData2 <= regs[readAddr2];
        end
        // Otherwise hold last value
    end

endmodule

`default_nettype wire

// File: design/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             opValid,
    input  execPkg::aluOp                    aluOp,
    input  logic                             useImm,
    input  logic [execPkg::dataWidth-1:0]    operandA,   // rs1 value
    input  logic [execPkg::dataWidth-1:0]    operandB,   // rs2 value
    input  logic [execPkg::dataWidth-1:0]    operandImm,
    input  logic [execPkg::regAddrWidth-1:0] rd,
    output logic                             wbValid,
    output logic [execPkg::regAddrWidth-1:0] wbReg,
    output logic [execPkg::dataWidth-1:0]    wbData
);

    logic [execPkg::dataWidth-1:0]  operandSel;
    logic [execPkg::shamtWidth-1:0] shamt;
    logic                           lessSigned;
    logic                           lessUnsigned;
    logic [execPkg::dataWidth-1:0]  result;

    // Second operand, register or immediate
    assign operandSel = useImm ? operandImm : operandB;
    assign shamt      = operandSel[execPkg::shamtWidth-1:0]; // Low five bits only

    assign lessSigned   = $signed(operandA) < $signed(operandSel);
    assign lessUnsigned = operandA < operandSel;

    always_comb begin
        case (aluOp)
            execPkg::aluAdd:  result = operandA + operandSel;
            execPkg::aluSub:  result = operandA - operandSel;
            execPkg::aluSll:  result = operandA << shamt;
            execPkg::aluSlt:  result = {{(execPkg::dataWidth-1){1'b0}}, lessSigned};
            execPkg::aluSltu: result = {{(execPkg::dataWidth-1){1'b0}}, lessUnsigned};
            execPkg::aluXor:  result = operandA ^ operandSel;
            execPkg::aluSrl:  result = operandA >> shamt;
            execPkg::aluSra:  result = $signed(operandA) >>> shamt; // Sign bit fills in
            execPkg::aluOr:   result = operandA | operandSel;
            execPkg::aluAnd:  result = operandA & operandSel;
            default:          result = '0;
        endcase
    end

    // Writeback strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= opValid; // Single cycle, follows the staged valid
        end
    end

    // Writeback payload
    always_ff @(posedge clock) begin
        if (opValid) begin
            wbReg  <= rd;
            wbData <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             instrReq,
    input  riscvPkg::instrWord               instr,
    output logic                             instrAck,
    output logic                             wbValid,
    output logic [execPkg::regAddrWidth-1:0] wbReg,
    output logic [execPkg::dataWidth-1:0]    wbData
);

    // Receiver to decoder
    logic                             issue;
    riscvPkg::instrWord               issuedInstr;

    // Decoder to register file
    logic [execPkg::regAddrWidth-1:0] rs1;
    logic [execPkg::regAddrWidth-1:0] rs2;
    logic                             readEn;

    // Staged controls to ALU
    logic [execPkg::regAddrWidth-1:0] rd;
    execPkg::aluOp                    stagedOp;
    logic                             useImm;
    logic [execPkg::dataWidth-1:0]    operandImm;
    logic                             opValid;

    // Register read data
    logic [execPkg::dataWidth-1:0]    readData1;
    logic [execPkg::dataWidth-1:0]    readData2;

    instrReceiver i_instrReceiver (
        .clock       (clock),
        .reset       (reset),
        .instrReq    (instrReq),
        .instr       (instr),
        .instrAck    (instrAck),
        .issue       (issue),
        .issuedInstr (issuedInstr)
    );

    instrDecoder i_instrDecoder (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issuedInstr (issuedInstr),
        .rs1         (rs1),
        .rs2         (rs2),
        .readEn      (readEn),
        .rd          (rd),
        .aluOp       (stagedOp),
        .useImm      (useImm),
        .operandImm  (operandImm),
        .opValid     (opValid)
    );

    // Write port fed back from the writeback outputs
    registerFile i_registerFile (
        .clock     (clock),
        .reset     (reset),
        .readAddr1 (rs1),
        .readAddr2 (rs2),
        .readEn    (readEn),
        .writeEn   (wbValid),
        .writeAddr (wbReg),
        .writeData (wbData),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    aluUnit i_aluUnit (
        .clock      (clock),
        .reset      (reset),
        .opValid    (opValid),
        .aluOp      (stagedOp),
        .useImm     (useImm),
        .operandA   (readData1),
        .operandB   (readData2),
        .operandImm (operandImm),
        .rd         (rd),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

endmodule

`default_nettype wire

// File: tests/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;

    localparam int clockPeriod    = 20;
    localparam int resetCycles    = 16;
    localparam int driveDelay     = 1;  // ns after the rising edge
    localparam int perOpCount     = 8;  // Random instructions per ALU operation
    localparam int instrCount     = 32 + 31 + 10 * perOpCount + 9 * perOpCount + 4 + 10 + 5;
    localparam int watchdogCycles = instrCount * 12 + resetCycles + 200;
    localparam int ackTimeout     = 20; // Cycles allowed for each handshake phase

    logic                             clock;
    logic                             reset;
    logic                             instrReq;
    riscvPkg::instrWord               instr;
    logic                             instrAck;
    logic                             wbValid;
    logic [execPkg::regAddrWidth-1:0] wbReg;
    logic [execPkg::dataWidth-1:0]    wbData;

    logic [execPkg::dataWidth-1:0] modelRegs [execPkg::regCount]; // Architectural state model
    logic [31:0]                   rngState;
    int                            cycleCount = 0;
    int                            valueErrors;
    int                            protocolErrors;
    string                         currentTest;

    // Expected writebacks in send order
    string       expName  [$];
    logic        expValid [$];
    logic [4:0]  expReg   [$];
    logic [31:0] expData  [$];
    int          expDue   [$]; // Cycle count where wbValid must show

    execCore i_execCore (
        .clock    (clock),
        .reset    (reset),
        .instrReq (instrReq),
        .instr    (instr),
        .instrAck (instrAck),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    always @(posedge clock) cycleCount <= cycleCount + 1; // Edge counter for timing checks

    // Xorshift32
    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic riscvPkg::instrWord makeR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        riscvPkg::instrWord w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = riscvPkg::opcodeOp;
        return w;
    endfunction

    // Opcode left open so unknown opcodes can be built too
    function automatic riscvPkg::instrWord makeI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
        riscvPkg::instrWord w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    // RV32I semantics from raw bit fields
    // Return value is the writeback valid
    function automatic logic refExecute(input logic [31:0] word, output logic [4:0] rdOut,
            output logic [31:0] dataOut);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        isReg;
        logic        alt;
        logic        legal;
        opcode = word[6:0];
        rdOut  = word[11:7];
        f3     = word[14:12];
        f7     = word[31:25];
        a      = modelRegs[word[19:15]];
        isReg  = opcode == riscvPkg::opcodeOp;
        alt    = f7 == 7'h20;
        if (isReg) begin
            b     = modelRegs[word[24:20]];
            legal = f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5)); // Only sub and sra
        end else begin
            b = {{20{word[31]}}, word[31:20]}; // Sign-extended imm12
            if (f3 == 3'd1) begin
                legal = f7 == 7'h00;
            end else if (f3 == 3'd5) begin
                legal = f7 == 7'h00 || alt;
            end else begin
                legal = 1'b1;
            end
            legal = legal && opcode == riscvPkg::opcodeOpImm; // Anything else is a no-op
        end
        sh = b[4:0];
        case (f3)
            3'd0:    dataOut = (isReg && alt) ? a - b : a + b;
            3'd1:    dataOut = a << sh;
            3'd2:    dataOut = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    dataOut = (a < b) ? 32'd1 : 32'd0;
            3'd4:    dataOut = a ^ b;
            3'd5: begin
                if (alt) begin
                    dataOut = $signed(a) >>> sh;
                end else begin
                    dataOut = a >> sh;
                end
            end
            3'd6:    dataOut = a | b;
            default: dataOut = a & b;
        endcase
        if (legal && rdOut != 5'd0) begin
            modelRegs[rdOut] = dataOut; // x0 stays zero
        end
        return legal;
    endfunction

    task automatic checkValue(input string testName, input string what,
            input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    // Full four-phase handshake plus one idle edge
    // Next accept lands at E+4
    task automatic sendInstr(input riscvPkg::instrWord word);
        logic        valid;
        logic [4:0]  rdExp;
        logic [31:0] dataExp;
        int          waited;
        @(posedge clock);
        #driveDelay;
        instr    = word;
        instrReq = 1'b1;
        waited   = 0;
        while (!instrAck && waited < ackTimeout) begin
            @(posedge clock);
            #driveDelay;
            waited++;
        end
        if (!instrAck) begin
            protocolErrors++;
            $display("instrAck did not rise in %s for word %h", currentTest, word);
            instrReq = 1'b0;
        end else begin
            if (waited != 1) begin
                protocolErrors++;
                $display("instrAck rose %0d edges after instrReq in %s instead of one",
                         waited, currentTest);
            end
            valid = refExecute(word, rdExp, dataExp); // Last edge was E
            expName.push_back(currentTest);
            expValid.push_back(valid);
            expReg.push_back(rdExp);
            expData.push_back(dataExp);
            expDue.push_back(cycleCount + 2);
            instrReq = 1'b0;
            waited   = 0;
            while (instrAck && waited < ackTimeout) begin
                @(posedge clock);
                #driveDelay;
                waited++;
            end
            if (instrAck) begin
                protocolErrors++;
                $display("instrAck stayed high after instrReq fell in %s", currentTest);
            end else if (waited != 1) begin
                protocolErrors++;
                $display("instrAck fell %0d edges after instrReq in %s instead of one",
                         waited, currentTest);
            end
            @(posedge clock);
        end
    endtask

    // Sampled mid-cycle where outputs are settled
    initial begin : compareWriteback
        forever begin
            @(negedge clock);
            if (expDue.size() > 0 && expDue[0] == cycleCount) begin
                if (expValid[0] && !wbValid) begin
                    protocolErrors++;
                    $display("Missing writeback in %s two cycles after accept", expName[0]);
                end else if (expValid[0]) begin
                    checkValue(expName[0], "wbReg", {27'd0, expReg[0]}, {27'd0, wbReg});
                    checkValue(expName[0], "wbData", expData[0], wbData);
                end else if (wbValid) begin
                    protocolErrors++;
                    $display("Writeback from a no-op in %s to x%0d", expName[0], wbReg);
                end
                void'(expName.pop_front());
                void'(expValid.pop_front());
                void'(expReg.pop_front());
                void'(expData.pop_front());
                void'(expDue.pop_front());
            end else if (wbValid) begin
                protocolErrors++;
                $display("Unexpected writeback to x%0d with data %h", wbReg, wbData);
            end
        end
    end

    initial begin : watchdog
        #(watchdogCycles * clockPeriod);
        $display("Timeout, the run did not finish within %0d cycles", watchdogCycles);
        $display("sim failed");
        $finish;
    end

    initial begin : mainSequence
        logic [31:0] rnd;
        int          n;
        instrReq       = 1'b0;
        instr          = '0;
        reset          = 1'b1;
        rngState       = 32'd46;
        valueErrors    = 0;
        protocolErrors = 0;
        for (int i = 0; i < execPkg::regCount; i++) begin
            modelRegs[i] = '0;
        end
        repeat (resetCycles) @(posedge clock);
        #driveDelay;
        reset = 1'b0;

        currentTest = "resetState"; // add xN, xN, x0
        for (int i = 0; i < 32; i++) begin
            sendInstr(makeR(riscvPkg::funct7Base, 5'd0, 5'(i), riscvPkg::funct3AddSub, 5'(i)));
        end

        currentTest = "immLoad";
        sendInstr(makeI(12'h7ff, 5'd0, riscvPkg::funct3AddSub, 5'd1, riscvPkg::opcodeOpImm));
        sendInstr(makeI(12'h800, 5'd0, riscvPkg::funct3AddSub, 5'd2, riscvPkg::opcodeOpImm));
        sendInstr(makeI(12'hfff, 5'd0, riscvPkg::funct3AddSub, 5'd3, riscvPkg::opcodeOpImm));
        for (int i = 4; i < 32; i++) begin
            rnd = nextRandom();
            sendInstr(makeI(rnd[11:0], 5'd0, riscvPkg::funct3AddSub, 5'(i),
                            riscvPkg::opcodeOpImm));
        end

        currentTest = "rType";
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < perOpCount; k++) begin
                rnd = nextRandom();
                sendInstr(makeR(riscvPkg::funct7Base, rnd[24:20], rnd[19:15], 3'(f), rnd[11:7]));
                if (f == 0 || f == 5) begin
                    rnd = nextRandom(); // sub or sra
                    sendInstr(makeR(riscvPkg::funct7Alt, rnd[24:20], rnd[19:15], 3'(f),
                                    rnd[11:7]));
                end
            end
        end

        currentTest = "iType";
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < perOpCount; k++) begin
                rnd = nextRandom();
                if (f == 1 || f == 5) begin
                    sendInstr(makeI({riscvPkg::funct7Base, rnd[24:20]}, rnd[19:15], 3'(f),
                                    rnd[11:7], riscvPkg::opcodeOpImm));
                end else begin
                    sendInstr(makeI(rnd[31:20], rnd[19:15], 3'(f), rnd[11:7],
                                    riscvPkg::opcodeOpImm));
                end
                if (f == 5) begin
                    rnd = nextRandom(); // srai
                    sendInstr(makeI({riscvPkg::funct7Alt, rnd[24:20]}, rnd[19:15], 3'(f),
                                    rnd[11:7], riscvPkg::opcodeOpImm));
                end
            end
        end

        currentTest = "x0Write";
        sendInstr(makeI(12'h07b, 5'd0, riscvPkg::funct3AddSub, 5'd0, riscvPkg::opcodeOpImm));
        sendInstr(makeR(riscvPkg::funct7Base, 5'd0, 5'd0, riscvPkg::funct3AddSub, 5'd5));
        sendInstr(makeR(riscvPkg::funct7Base, 5'd2, 5'd1, riscvPkg::funct3Or, 5'd0));
        sendInstr(makeI(12'hfff, 5'd0, riscvPkg::funct3Xor, 5'd6, riscvPkg::opcodeOpImm));

        currentTest = "illegalOp";
        sendInstr(makeI(12'h123, 5'd1, 3'd0, 5'd9, 7'b0000011)); // Load
        sendInstr(makeI(12'h123, 5'd1, 3'd2, 5'd9, 7'b0100011)); // Store
        sendInstr(makeI(12'h010, 5'd1, 3'd0, 5'd9, 7'b1100011)); // Branch
        sendInstr(makeI(12'habc, 5'd1, 3'd5, 5'd9, 7'b0110111)); // LUI
        sendInstr(makeI(12'h000, 5'd0, 3'd0, 5'd9, 7'b1110011)); // System
        sendInstr(makeR(7'h01, 5'd2, 5'd1, riscvPkg::funct3AddSub, 5'd9)); // mul encoding
        sendInstr(makeR(riscvPkg::funct7Alt, 5'd2, 5'd1, riscvPkg::funct3Sll, 5'd9));
        sendInstr(makeI({riscvPkg::funct7Alt, 5'd3}, 5'd1, riscvPkg::funct3Sll, 5'd9,
                        riscvPkg::opcodeOpImm));
        sendInstr(makeI({7'h10, 5'd3}, 5'd1, riscvPkg::funct3SrlSra, 5'd9,
                        riscvPkg::opcodeOpImm));
        sendInstr(makeR(riscvPkg::funct7Base, 5'd0, 5'd9, riscvPkg::funct3AddSub, 5'd10));

        currentTest = "backToBack"; // Each reads the value committed just before
        sendInstr(makeI(12'h005, 5'd0, riscvPkg::funct3AddSub, 5'd7, riscvPkg::opcodeOpImm));
        sendInstr(makeI(12'h003, 5'd7, riscvPkg::funct3AddSub, 5'd7, riscvPkg::opcodeOpImm));
        sendInstr(makeR(riscvPkg::funct7Base, 5'd7, 5'd7, riscvPkg::funct3AddSub, 5'd8));
        sendInstr(makeR(riscvPkg::funct7Alt, 5'd7, 5'd8, riscvPkg::funct3AddSub, 5'd8));
        sendInstr(makeR(riscvPkg::funct7Base, 5'd7, 5'd8, riscvPkg::funct3Sll, 5'd11));

        n = 0;
        while (expDue.size() > 0 && n < 20) begin
            @(posedge clock);
            n++;
        end
        repeat (4) @(posedge clock); // Room for a stray late writeback
        if (expDue.size() > 0) begin
            protocolErrors++;
            $display("Expected writebacks were never checked");
        end
        $display("Errors: %0d wrong values, %0d protocol errors", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/riscvPkg.sv
common/execPkg.sv
design/instrReceiver.sv
design/instrDecoder.sv
design/registerFile.sv
design/aluUnit.sv
design/execCore.sv
tests/execCoreTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = execCoreTb
FILELIST  = list.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
